// ==== design/riscv_isa_pkg.sv ====
// RV32I subset definitions: widths, opcodes, funct codes and ALU operations
`default_nettype none

package riscv_isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [31:0]           instr_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Major opcodes in bits 6:0
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011
    } opcode_t;

    // ADD first so that an all-zero control word is harmless
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_t;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_LW      = 3'b010;
    localparam logic [2:0] F3_SW      = 3'b010;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    // addi x0, x0, 0
    localparam instr_t NOP_INSTR = 32'h0000_0013;

endpackage

`default_nettype wire

// ==== design/riscv_pipe_pkg.sv ====
// Pipeline definitions: stage controls, forwarding selects and pipeline register contents
`default_nettype none

package riscv_pipe_pkg;

    // One per pipeline register and the PC
    typedef enum logic [1:0] {
        ENABLE,
        STALL,
        FLUSH
    } stage_ctrl_t;

    // Operand source for execute
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

    // All control structs are zero on reset and then mean no effect
    typedef struct packed {
        riscv_isa_pkg::alu_op_t alu_op;
        logic                   imm_sel;
    } ex_ctrl_t;

    typedef struct packed {
        logic read;
        logic write;
    } mem_ctrl_t;

    typedef struct packed {
        logic wr_en;
        logic mem_to_reg;
    } wb_ctrl_t;

    typedef struct packed {
        riscv_isa_pkg::word_t  pc;
        riscv_isa_pkg::instr_t instr;
    } if_dec_t;

    typedef struct packed {
        ex_ctrl_t                ex;
        mem_ctrl_t               mem;
        wb_ctrl_t                wb;
        riscv_isa_pkg::word_t    imm;
        riscv_isa_pkg::word_t    rs1_value;
        riscv_isa_pkg::word_t    rs2_value;
        riscv_isa_pkg::reg_addr_t rd;
        riscv_isa_pkg::reg_addr_t rs1;
        riscv_isa_pkg::reg_addr_t rs2;
    } dec_ex_t;

    typedef struct packed {
        mem_ctrl_t                mem;
        wb_ctrl_t                 wb;
        riscv_isa_pkg::word_t     alu_result;
        riscv_isa_pkg::word_t     store_data;
        riscv_isa_pkg::reg_addr_t rd;
    } ex_mem_t;

    typedef struct packed {
        wb_ctrl_t                 wb;
        riscv_isa_pkg::word_t     alu_result;
        riscv_isa_pkg::word_t     load_data;
        riscv_isa_pkg::reg_addr_t rd;
    } mem_wb_t;

endpackage

`default_nettype wire

// ==== design/riscv_regfile_if.sv ====
// Register file link between decode reads and writeback writes
`timescale 1ns/10ps
`default_nettype none

interface riscv_regfile_if;
    import riscv_isa_pkg::*;

    // Read side, driven by decode
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;

    // Write side, driven from writeback
    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;

    modport decoder (output rs1_addr, rs2_addr, input rs1_data, rs2_data);
    modport storage (input rs1_addr, rs2_addr, wr_en, wr_addr, wr_data,
                     output rs1_data, rs2_data);
    modport writeback (output wr_en, wr_addr, wr_data);

endinterface

`default_nettype wire

// ==== design/riscv_regfile.sv ====
// Register file with 31 writable registers, two read ports and write-first bypass
`timescale 1ns/10ps
`default_nettype none

module riscv_regfile (
    input  logic                    CLK,
    input  logic                    arst_n,
    riscv_regfile_if.storage        rf
);
    import riscv_isa_pkg::*;

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.wr_en && rf.wr_addr != '0) begin
            regs[rf.wr_addr] <= rf.wr_data;
        end
    end

    // Write in the same cycle wins, so decode sees the new value
    assign rf.rs1_data = (rf.rs1_addr == '0) ? '0 :
                         (rf.wr_en && rf.wr_addr == rf.rs1_addr) ? rf.wr_data :
                         regs[rf.rs1_addr];

    assign rf.rs2_data = (rf.rs2_addr == '0) ? '0 :
                         (rf.wr_en && rf.wr_addr == rf.rs2_addr) ? rf.wr_data :
                         regs[rf.rs2_addr];

endmodule

`default_nettype wire

// ==== design/riscv_fetch.sv ====
// Fetch stage program counter with hold, sequential advance and branch redirect
`timescale 1ns/10ps
`default_nettype none

module riscv_fetch (
    input  logic                        CLK,
    input  logic                        arst_n,
    input  riscv_pipe_pkg::stage_ctrl_t pc_ctrl,
    input  logic                        branch_taken,
    input  riscv_isa_pkg::word_t        branch_target,
    output riscv_isa_pkg::word_t        pc
);
    import riscv_pipe_pkg::*;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (pc_ctrl != STALL) begin
            // Branch resolved in decode redirects on this edge
            if (branch_taken) begin
                pc <= branch_target;
            end else begin
                pc <= pc + 32'd4;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/riscv_decode.sv ====
// Decode stage: control decoding, immediates, operand read and branch resolution
`timescale 1ns/10ps
`default_nettype none

module riscv_decode (
    input  riscv_isa_pkg::instr_t     instr,
    input  riscv_isa_pkg::word_t      pc,
    riscv_regfile_if.decoder          rf,
    input  riscv_isa_pkg::reg_addr_t  fwd_mem_rd,
    input  riscv_isa_pkg::word_t      fwd_mem_value,
    output riscv_pipe_pkg::ex_ctrl_t  ex_ctrl,
    output riscv_pipe_pkg::mem_ctrl_t mem_ctrl,
    output riscv_pipe_pkg::wb_ctrl_t  wb_ctrl,
    output riscv_isa_pkg::word_t      imm,
    output riscv_isa_pkg::word_t      rs1_value,
    output riscv_isa_pkg::word_t      rs2_value,
    output riscv_isa_pkg::reg_addr_t  rd,
    output riscv_isa_pkg::reg_addr_t  rs1,
    output riscv_isa_pkg::reg_addr_t  rs2,
    output logic                      branch_taken,
    output riscv_isa_pkg::word_t      branch_target,
    output logic                      uses_rs2
);
    import riscv_isa_pkg::*;
    import riscv_pipe_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_beq;
    logic       is_bne;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign rf.rs1_addr = rs1;
    assign rf.rs2_addr = rs2;

    // Memory-stage result overrides the register file
    assign rs1_value = (rs1 != '0 && rs1 == fwd_mem_rd) ? fwd_mem_value : rf.rs1_data;
    assign rs2_value = (rs2 != '0 && rs2 == fwd_mem_rd) ? fwd_mem_value : rf.rs2_data;

    always_comb begin
        ex_ctrl  = '0;
        mem_ctrl = '0;
        wb_ctrl  = '0;
        imm      = '0;
        uses_rs2 = 1'b0;
        is_beq   = 1'b0;
        is_bne   = 1'b0;
        case (opcode_t'(instr[6:0]))
            OPC_OP: begin
                uses_rs2      = 1'b1;
                wb_ctrl.wr_en = 1'b1;
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD_SUB}: ex_ctrl.alu_op = ALU_ADD;
                    {F7_SUB, F3_ADD_SUB}:  ex_ctrl.alu_op = ALU_SUB;
                    {F7_BASE, F3_SLT}:     ex_ctrl.alu_op = ALU_SLT;
                    {F7_BASE, F3_XOR}:     ex_ctrl.alu_op = ALU_XOR;
                    {F7_BASE, F3_OR}:      ex_ctrl.alu_op = ALU_OR;
                    {F7_BASE, F3_AND}:     ex_ctrl.alu_op = ALU_AND;
                    // Unsupported R-type is a no-op
                    default:               wb_ctrl.wr_en  = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                ex_ctrl.imm_sel = 1'b1;
                wb_ctrl.wr_en   = 1'b1;
                imm             = {{20{instr[31]}}, instr[31:20]};
                case (funct3)
                    F3_ADD_SUB: ex_ctrl.alu_op = ALU_ADD;
                    F3_XOR:     ex_ctrl.alu_op = ALU_XOR;
                    F3_OR:      ex_ctrl.alu_op = ALU_OR;
                    F3_AND:     ex_ctrl.alu_op = ALU_AND;
                    default:    wb_ctrl.wr_en  = 1'b0;
                endcase
            end
            OPC_LUI: begin
                ex_ctrl.alu_op  = ALU_PASS_B;
                ex_ctrl.imm_sel = 1'b1;
                wb_ctrl.wr_en   = 1'b1;
                imm             = {instr[31:12], 12'b0};
            end
            OPC_LOAD: begin
                if (funct3 == F3_LW) begin
                    ex_ctrl.imm_sel    = 1'b1;
                    mem_ctrl.read      = 1'b1;
                    wb_ctrl.wr_en      = 1'b1;
                    wb_ctrl.mem_to_reg = 1'b1;
                    imm                = {{20{instr[31]}}, instr[31:20]};
                end
            end
            OPC_STORE: begin
                if (funct3 == F3_SW) begin
                    uses_rs2        = 1'b1;
                    ex_ctrl.imm_sel = 1'b1;
                    mem_ctrl.write  = 1'b1;
                    imm             = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                end
            end
            OPC_BRANCH: begin
                uses_rs2 = 1'b1;
                imm      = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
                is_beq   = (funct3 == F3_BEQ);
                is_bne   = (funct3 == F3_BNE);
            end
            default: ;
        endcase
    end

    // Branch compare on the forwarded operands
    assign branch_taken  = (is_beq && rs1_value == rs2_value) ||
                           (is_bne && rs1_value != rs2_value);
    assign branch_target = pc + imm;

endmodule

`default_nettype wire

// ==== design/riscv_hazard_unit.sv ====
// Hazard unit: stage controls for stalls and flushes, and execute forwarding selects
`timescale 1ns/10ps
`default_nettype none

module riscv_hazard_unit (
    input  logic                        en,
    input  logic                        branch_taken,
    input  riscv_isa_pkg::reg_addr_t    dec_rs1,
    input  riscv_isa_pkg::reg_addr_t    dec_rs2,
    input  logic                        dec_uses_rs2,
    input  riscv_isa_pkg::reg_addr_t    ex_rd,
    input  riscv_isa_pkg::reg_addr_t    ex_rs1,
    input  riscv_isa_pkg::reg_addr_t    ex_rs2,
    input  logic                        ex_mem_read,
    input  riscv_isa_pkg::reg_addr_t    mem_rd,
    input  riscv_isa_pkg::reg_addr_t    wb_rd,
    input  logic                        mem_wr_en,
    input  logic                        wb_wr_en,
    output riscv_pipe_pkg::stage_ctrl_t pc_ctrl,
    output riscv_pipe_pkg::stage_ctrl_t if_dec_ctrl,
    output riscv_pipe_pkg::stage_ctrl_t dec_ex_ctrl,
    output riscv_pipe_pkg::stage_ctrl_t ex_mem_ctrl,
    output riscv_pipe_pkg::stage_ctrl_t mem_wb_ctrl,
    output riscv_pipe_pkg::fwd_sel_t    fwd_a,
    output riscv_pipe_pkg::fwd_sel_t    fwd_b
);
    import riscv_isa_pkg::*;
    import riscv_pipe_pkg::*;

    logic load_use;

    // Youngest writer wins, x0 never forwards
    function automatic fwd_sel_t pick_source(reg_addr_t src, reg_addr_t m_rd, logic m_we,
                                             reg_addr_t w_rd, logic w_we);
        if (src != '0 && m_we && m_rd == src) begin
            return FWD_MEM;
        end
        if (src != '0 && w_we && w_rd == src) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    // Load in execute feeding decode, branches included
    assign load_use = ex_mem_read && ex_rd != '0 &&
                      (ex_rd == dec_rs1 || (dec_uses_rs2 && ex_rd == dec_rs2));

    always_comb begin
        pc_ctrl     = ENABLE;
        if_dec_ctrl = ENABLE;
        dec_ex_ctrl = ENABLE;
        ex_mem_ctrl = ENABLE;
        mem_wb_ctrl = ENABLE;
        if (!en) begin
            // Whole pipeline frozen
            pc_ctrl     = STALL;
            if_dec_ctrl = STALL;
            dec_ex_ctrl = STALL;
            ex_mem_ctrl = STALL;
            mem_wb_ctrl = STALL;
        end else if (load_use) begin
            // Hold fetch and decode, bubble into execute
            pc_ctrl     = STALL;
            if_dec_ctrl = STALL;
            dec_ex_ctrl = FLUSH;
        end else if (branch_taken) begin
            // Drop the slot fetched behind the branch
            if_dec_ctrl = FLUSH;
        end
    end

    assign fwd_a = pick_source(ex_rs1, mem_rd, mem_wr_en, wb_rd, wb_wr_en);
    assign fwd_b = pick_source(ex_rs2, mem_rd, mem_wr_en, wb_rd, wb_wr_en);

endmodule

`default_nettype wire

// ==== design/riscv_execute.sv ====
// Execute stage: operand forwarding multiplexers and the ALU
`timescale 1ns/10ps
`default_nettype none

module riscv_execute (
    input  riscv_pipe_pkg::ex_ctrl_t ex_ctrl,
    input  riscv_pipe_pkg::fwd_sel_t fwd_a,
    input  riscv_pipe_pkg::fwd_sel_t fwd_b,
    input  riscv_isa_pkg::word_t     rs1_value,
    input  riscv_isa_pkg::word_t     rs2_value,
    input  riscv_isa_pkg::word_t     imm,
    input  riscv_isa_pkg::word_t     mem_value,
    input  riscv_isa_pkg::word_t     wb_value,
    output riscv_isa_pkg::word_t     alu_result,
    output riscv_isa_pkg::word_t     store_data
);
    import riscv_isa_pkg::*;
    import riscv_pipe_pkg::*;

    word_t op_a;
    word_t op_b;

    function automatic word_t select_operand(fwd_sel_t sel, word_t reg_v,
                                             word_t mem_v, word_t wb_v);
        case (sel)
            FWD_MEM: return mem_v;
            FWD_WB:  return wb_v;
            default: return reg_v;
        endcase
    endfunction

    assign op_a       = select_operand(fwd_a, rs1_value, mem_value, wb_value);
    // Forwarded rs2 also feeds the store data
    assign store_data = select_operand(fwd_b, rs2_value, mem_value, wb_value);
    assign op_b       = ex_ctrl.imm_sel ? imm : store_data;

    always_comb begin
        case (ex_ctrl.alu_op)
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_OR:     alu_result = op_a | op_b;
            ALU_XOR:    alu_result = op_a ^ op_b;
            // Signed compare
            ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = op_a + op_b;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/riscv_core.sv ====
// Five-stage RV32I subset core with pipeline registers, hazard control and writeback select
`timescale 1ns/10ps
`default_nettype none

module riscv_core (
    input  logic                  CLK,
    input  logic                  arst_n,
    input  logic                  en,
    output riscv_isa_pkg::word_t  instr_addr,
    input  riscv_isa_pkg::instr_t instr_rdata,
    output riscv_isa_pkg::word_t  data_addr,
    output riscv_isa_pkg::word_t  data_wdata,
    output logic                  data_we,
    output logic                  data_re,
    input  riscv_isa_pkg::word_t  data_rdata
);
    import riscv_isa_pkg::*;
    import riscv_pipe_pkg::*;

    // Pipeline registers
    if_dec_t if_dec;
    dec_ex_t dec_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;

    stage_ctrl_t pc_ctrl;
    stage_ctrl_t if_dec_ctrl;
    stage_ctrl_t dec_ex_ctrl;
    stage_ctrl_t ex_mem_ctrl;
    stage_ctrl_t mem_wb_ctrl;
    fwd_sel_t    fwd_a;
    fwd_sel_t    fwd_b;

    word_t     pc;
    dec_ex_t   dec_out;
    logic      branch_taken;
    word_t     branch_target;
    logic      uses_rs2;
    word_t     alu_result;
    word_t     store_data;
    word_t     mem_result;
    word_t     wb_value;
    reg_addr_t mem_fwd_rd;

    riscv_regfile_if rf_bus ();

    riscv_fetch u_fetch (
        .CLK           (CLK),
        .arst_n        (arst_n),
        .pc_ctrl       (pc_ctrl),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .pc            (pc)
    );

    assign instr_addr = pc;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            if_dec <= '{pc: '0, instr: NOP_INSTR};
        end else if (if_dec_ctrl == FLUSH) begin
            if_dec <= '{pc: '0, instr: NOP_INSTR};
        end else if (if_dec_ctrl == ENABLE) begin
            if_dec <= '{pc: pc, instr: instr_rdata};
        end
    end

    // Only a writing instruction in memory may forward to decode
    assign mem_fwd_rd = ex_mem.wb.wr_en ? ex_mem.rd : '0;

    riscv_decode u_decode (
        .instr         (if_dec.instr),
        .pc            (if_dec.pc),
        .rf            (rf_bus.decoder),
        .fwd_mem_rd    (mem_fwd_rd),
        .fwd_mem_value (mem_result),
        .ex_ctrl       (dec_out.ex),
        .mem_ctrl      (dec_out.mem),
        .wb_ctrl       (dec_out.wb),
        .imm           (dec_out.imm),
        .rs1_value     (dec_out.rs1_value),
        .rs2_value     (dec_out.rs2_value),
        .rd            (dec_out.rd),
        .rs1           (dec_out.rs1),
        .rs2           (dec_out.rs2),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .uses_rs2      (uses_rs2)
    );

    riscv_regfile u_regfile (
        .CLK    (CLK),
        .arst_n (arst_n),
        .rf     (rf_bus.storage)
    );

    riscv_hazard_unit u_hazard (
        .en           (en),
        .branch_taken (branch_taken),
        .dec_rs1      (dec_out.rs1),
        .dec_rs2      (dec_out.rs2),
        .dec_uses_rs2 (uses_rs2),
        .ex_rd        (dec_ex.rd),
        .ex_rs1       (dec_ex.rs1),
        .ex_rs2       (dec_ex.rs2),
        .ex_mem_read  (dec_ex.mem.read),
        .mem_rd       (ex_mem.rd),
        .wb_rd        (mem_wb.rd),
        .mem_wr_en    (ex_mem.wb.wr_en),
        .wb_wr_en     (mem_wb.wb.wr_en),
        .pc_ctrl      (pc_ctrl),
        .if_dec_ctrl  (if_dec_ctrl),
        .dec_ex_ctrl  (dec_ex_ctrl),
        .ex_mem_ctrl  (ex_mem_ctrl),
        .mem_wb_ctrl  (mem_wb_ctrl),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b)
    );

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            dec_ex <= '0;
        end else if (dec_ex_ctrl == FLUSH) begin
            // Bubble with no write and no memory access
            dec_ex <= '0;
        end else if (dec_ex_ctrl == ENABLE) begin
            dec_ex <= dec_out;
        end
    end

    riscv_execute u_execute (
        .ex_ctrl    (dec_ex.ex),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b),
        .rs1_value  (dec_ex.rs1_value),
        .rs2_value  (dec_ex.rs2_value),
        .imm        (dec_ex.imm),
        .mem_value  (mem_result),
        .wb_value   (wb_value),
        .alu_result (alu_result),
        .store_data (store_data)
    );

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem <= '0;
        end else if (ex_mem_ctrl == FLUSH) begin
            ex_mem <= '0;
        end else if (ex_mem_ctrl == ENABLE) begin
            ex_mem <= '{mem: dec_ex.mem, wb: dec_ex.wb, alu_result: alu_result,
                        store_data: store_data, rd: dec_ex.rd};
        end
    end

    // Memory stage, strobes frozen with the pipeline
    assign data_addr  = ex_mem.alu_result;
    assign data_wdata = ex_mem.store_data;
    assign data_we    = ex_mem.mem.write & en;
    assign data_re    = ex_mem.mem.read & en;
    // Load data is already valid in this stage
    assign mem_result = ex_mem.mem.read ? data_rdata : ex_mem.alu_result;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            mem_wb <= '0;
        end else if (mem_wb_ctrl == FLUSH) begin
            mem_wb <= '0;
        end else if (mem_wb_ctrl == ENABLE) begin
            mem_wb <= '{wb: ex_mem.wb, alu_result: ex_mem.alu_result,
                        load_data: data_rdata, rd: ex_mem.rd};
        end
    end

    // Writeback select
    assign wb_value = mem_wb.wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

    assign rf_bus.wr_en   = mem_wb.wb.wr_en & en;
    assign rf_bus.wr_addr = mem_wb.rd;
    assign rf_bus.wr_data = wb_value;

endmodule

`default_nettype wire

// ==== verification/riscv_core_tb.sv ====
// Testbench for the pipelined RV32I subset core with memory models and store checking
`timescale 1ns/10ps
`default_nettype none

module riscv_core_tb;
    import riscv_isa_pkg::*;

    localparam int         CLK_PERIOD    = 100;
    localparam int         RESET_CYCLES  = 8;
    localparam int         FREEZE_CYCLES = 10;
    localparam logic [5:0] FREEZE_AFTER  = 6'd4;
    // Target of the slot behind the taken branch
    localparam word_t      POISON_ADDR   = 32'h0000_00F0;
    localparam word_t      LOAD_ADDR     = 32'h0000_0040;

    logic   CLK;
    logic   arst_n;
    logic   en;
    word_t  instr_addr;
    instr_t instr_rdata;
    word_t  data_addr;
    word_t  data_wdata;
    logic   data_we;
    logic   data_re;
    word_t  data_rdata;

    // Word-indexed memories
    instr_t imem [0:63];
    word_t  dmem [0:63];

    // Register model and expected stores in program order
    word_t      model    [0:31];
    word_t      exp_pc   [0:63];
    word_t      exp_addr [0:63];
    word_t      exp_data [0:63];
    logic [5:0] exp_count;
    logic [5:0] store_idx;
    // Fetch address of the only load
    word_t      load_pc;

    int   prog_len;
    int   seed;
    logic program_ready;

    // Fetch addresses of the last three enabled cycles
    word_t fetch_hist [0:2];
    logic  rst_q;
    logic  prev_en;
    word_t prev_addr;

    riscv_core DUT (
        .CLK         (CLK),
        .arst_n      (arst_n),
        .en          (en),
        .instr_addr  (instr_addr),
        .instr_rdata (instr_rdata),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_we     (data_we),
        .data_re     (data_re),
        .data_rdata  (data_rdata)
    );

    // Both memories answer in the same cycle
    assign instr_rdata = imem[instr_addr[7:2]];
    assign data_rdata  = dmem[data_addr[7:2]];

    initial begin
        CLK = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            CLK = ~CLK;
        end
    end

    function automatic word_t fill_word(input word_t addr);
        return 32'hDA7A_0000 ^ addr;
    endfunction

    // Positive 11-bit immediate
    function automatic logic [11:0] random_imm();
        word_t r;
        r = $random(seed);
        return {1'b0, r[10:0]};
    endfunction

    function automatic instr_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                      input reg_addr_t rs1, input logic [2:0] f3,
                                      input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic instr_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                      input logic [2:0] f3, input reg_addr_t rd,
                                      input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic instr_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                      input reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, F3_SW, imm[4:0], OPC_STORE};
    endfunction

    function automatic instr_t b_type(input logic [12:0] imm, input reg_addr_t rs2,
                                      input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic instr_t u_type(input logic [19:0] imm, input reg_addr_t rd);
        return {imm, rd, OPC_LUI};
    endfunction

    task automatic place(input instr_t word);
        imem[prog_len[5:0]] = word;
        prog_len = prog_len + 1;
    endtask

    task automatic addi_to(input reg_addr_t rd, input reg_addr_t rs1, input logic [11:0] imm);
        place(i_type(imm, rs1, F3_ADD_SUB, rd, OPC_OP_IMM));
        if (rd != 5'd0) begin
            model[rd] = model[rs1] + {{20{imm[11]}}, imm};
        end
    endtask

    // Register-register semantics from the ISA
    task automatic alu_reg(input logic [6:0] f7, input logic [2:0] f3, input reg_addr_t rd,
                           input reg_addr_t rs1, input reg_addr_t rs2);
        word_t a;
        word_t b;
        word_t r;
        a = model[rs1];
        b = model[rs2];
        case ({f7, f3})
            {F7_SUB, F3_ADD_SUB}: r = a - b;
            {F7_BASE, F3_AND}:    r = a & b;
            {F7_BASE, F3_OR}:     r = a | b;
            {F7_BASE, F3_XOR}:    r = a ^ b;
            {F7_BASE, F3_SLT}:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:              r = a + b;
        endcase
        place(r_type(f7, rs2, rs1, f3, rd));
        if (rd != 5'd0) begin
            model[rd] = r;
        end
    endtask

    task automatic lui_to(input reg_addr_t rd, input logic [19:0] imm);
        place(u_type(imm, rd));
        model[rd] = {imm, 12'b0};
    endtask

    // Base is always x0
    task automatic load_to(input reg_addr_t rd, input logic [11:0] offset);
        load_pc = prog_len * 4;
        place(i_type(offset, 5'd0, F3_LW, rd, OPC_LOAD));
        model[rd] = fill_word({20'b0, offset});
    endtask

    task automatic store_from(input reg_addr_t rs2, input logic [11:0] offset);
        exp_pc[exp_count]   = prog_len * 4;
        exp_addr[exp_count] = {20'b0, offset};
        exp_data[exp_count] = model[rs2];
        exp_count           = exp_count + 6'd1;
        place(s_type(offset, rs2, 5'd0));
    endtask

    task automatic build_program();
        logic [11:0] imm_a;
        logic [11:0] imm_b;
        logic [11:0] imm_c;
        logic [11:0] imm_d;
        logic [11:0] imm_e;
        // Unused words are no-ops that carry their own index
        for (int i = 0; i < 64; i++) begin
            imem[i[5:0]] = i_type(i[11:0], 5'd0, F3_ADD_SUB, 5'd0, OPC_OP_IMM);
        end
        for (int i = 0; i < 32; i++) begin
            model[i[4:0]] = '0;
        end
        prog_len  = 0;
        exp_count = '0;
        imm_a = random_imm();
        imm_b = random_imm();
        imm_c = random_imm();
        imm_d = random_imm();
        imm_e = random_imm();
        // Dependent chain through both forwarding paths
        addi_to(5'd1, 5'd0, imm_a);
        addi_to(5'd2, 5'd0, imm_b);
        alu_reg(F7_BASE, F3_ADD_SUB, 5'd3, 5'd1, 5'd2);
        alu_reg(F7_SUB, F3_ADD_SUB, 5'd4, 5'd3, 5'd1);
        alu_reg(F7_BASE, F3_AND, 5'd5, 5'd4, 5'd2);
        alu_reg(F7_BASE, F3_OR, 5'd6, 5'd5, 5'd3);
        alu_reg(F7_BASE, F3_XOR, 5'd7, 5'd6, 5'd4);
        // Negative operand for the signed compare
        alu_reg(F7_SUB, F3_ADD_SUB, 5'd9, 5'd1, 5'd3);
        alu_reg(F7_BASE, F3_SLT, 5'd8, 5'd9, 5'd7);
        lui_to(5'd10, {imm_c[10:0], imm_a[8:0]});
        alu_reg(F7_BASE, F3_ADD_SUB, 5'd11, 5'd10, 5'd8);
        // Newest result first so store data forwards
        store_from(5'd11, 12'h080);
        store_from(5'd10, 12'h084);
        store_from(5'd9, 12'h088);
        store_from(5'd8, 12'h08C);
        store_from(5'd7, 12'h090);
        store_from(5'd6, 12'h094);
        store_from(5'd5, 12'h098);
        store_from(5'd4, 12'h09C);
        store_from(5'd3, 12'h0A0);
        // Load then dependent add
        addi_to(5'd13, 5'd0, imm_d);
        load_to(5'd12, LOAD_ADDR[11:0]);
        alu_reg(F7_BASE, F3_ADD_SUB, 5'd14, 5'd12, 5'd13);
        store_from(5'd14, 12'h0C0);
        // Equal operands so BEQ takes and BNE falls through
        addi_to(5'd15, 5'd0, imm_e);
        addi_to(5'd16, 5'd0, imm_e);
        store_from(5'd15, 12'h0C4);
        place(b_type(13'd8, 5'd16, 5'd15, F3_BEQ));
        place(s_type(POISON_ADDR[11:0], 5'd15, 5'd0));
        place(b_type(13'd8, 5'd16, 5'd15, F3_BNE));
        store_from(5'd16, 12'h0C8);
        // Write to x0 is dropped
        addi_to(5'd0, 5'd1, imm_a);
        store_from(5'd0, 12'h0CC);
    endtask

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    // Data memory, store counter and fetch history
    always @(posedge CLK) begin
        rst_q     <= arst_n;
        prev_en   <= en;
        prev_addr <= instr_addr;
        if (!arst_n) begin
            store_idx <= '0;
            for (int i = 0; i < 64; i++) begin
                dmem[i[5:0]] <= fill_word({24'b0, i[5:0], 2'b00});
            end
        end else begin
            if (data_we) begin
                dmem[data_addr[7:2]] <= data_wdata;
                store_idx            <= store_idx + 6'd1;
            end
            // Frozen cycles do not advance the pipeline
            if (en) begin
                fetch_hist[0] <= instr_addr;
                fetch_hist[1] <= fetch_hist[0];
                fetch_hist[2] <= fetch_hist[1];
            end
        end
    end

    reset_idle: assert property (@(posedge CLK)
            (!arst_n || !rst_q) |-> (instr_addr == '0 && !data_we && !data_re))
        else abort_run($sformatf("Fail at %0d ns: core not idle around reset", $time));

    store_value: assert property (@(posedge CLK)
            data_we |-> (store_idx < exp_count && data_addr == exp_addr[store_idx]
                         && data_wdata == exp_data[store_idx]))
        else abort_run($sformatf("Fail at %0d ns: store address or data mismatch", $time));

    store_latency: assert property (@(posedge CLK)
            data_we |-> fetch_hist[2] == exp_pc[store_idx])
        else abort_run($sformatf("Fail at %0d ns: store not three cycles after fetch", $time));

    poison_untouched: assert property (@(posedge CLK)
            data_we |-> data_addr != POISON_ADDR)
        else abort_run($sformatf("Fail at %0d ns: flushed store reached memory", $time));

    load_address: assert property (@(posedge CLK)
            data_re |-> data_addr == LOAD_ADDR)
        else abort_run($sformatf("Fail at %0d ns: load read the wrong address", $time));

    // Load in memory three cycles after fetch, dependent add held in decode
    load_use_stall: assert property (@(posedge CLK)
            (en && fetch_hist[2] == load_pc) |-> (data_re && instr_addr == fetch_hist[0]))
        else abort_run($sformatf("Fail at %0d ns: load without read strobe or stall", $time));

    freeze_strobes: assert property (@(posedge CLK)
            !en |-> (!data_we && !data_re))
        else abort_run($sformatf("Fail at %0d ns: memory strobe while frozen", $time));

    freeze_fetch: assert property (@(posedge CLK)
            (!en && !prev_en) |-> instr_addr == prev_addr)
        else abort_run($sformatf("Fail at %0d ns: fetch address moved while frozen", $time));

    initial begin
        program_ready = 1'b0;
        arst_n <= 1'b0;
        en     <= 1'b1;
        seed = 69;
        build_program();
        program_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLK);
        arst_n <= 1'b1;
        // Freeze while result stores are in flight
        while (store_idx < FREEZE_AFTER) begin
            @(posedge CLK);
        end
        en <= 1'b0;
        repeat (FREEZE_CYCLES) @(posedge CLK);
        en <= 1'b1;
        while (store_idx < exp_count) begin
            @(posedge CLK);
        end
        // Room for a stray store behind the last one
        repeat (4) @(posedge CLK);
        $display("Result: PASSED");
        $finish;
    end

    // Budget of twice the program plus the freeze
    initial begin
        wait (program_ready);
        #(CLK_PERIOD * (RESET_CYCLES + 2 * (prog_len + FREEZE_CYCLES)));
        abort_run("Watchdog expired because the core never reached the final store");
    end

endmodule

`default_nettype wire

// ==== project.f ====
design/riscv_isa_pkg.sv
design/riscv_pipe_pkg.sv
design/riscv_regfile_if.sv
design/riscv_regfile.sv
design/riscv_fetch.sv
design/riscv_decode.sv
design/riscv_hazard_unit.sv
design/riscv_execute.sv
design/riscv_core.sv
verification/riscv_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timescale 1ns/10ps --top-module riscv_core_tb \
    -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/Vriscv_core_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1
